//--- files.f
+incdir+.
rob_pkg.sv
rob_ctrl.sv
rob_entry_array.sv
rob_operand_lookup.sv
rob_top.sv
rob_asserts.sv
tb_rob.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tb_rob
FILELIST   := files.f
OBJ_DIR    := obj_dir
BUILD_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_rob.sv
/*
 * Reorder buffer testbench
 * Credit-limited dispatch, out-of-order writeback and random commit
 * back-pressure, checked against a slot-indexed reference model
 */

`timescale 1ns/10ps
`include "rob_defines.svh"

module tb_rob;

   import rob_pkg::*;

   localparam int DEPTH      = 1 << `ROB_DEPTH_W;
   localparam int RST_CYCLES = 4;
   localparam int N_OPS      = 400;
   localparam int FLUSH_AT   = 220;
   // Random phase, drain of a full ROB and a margin
   localparam int MAX_CYCLES = RST_CYCLES + N_OPS + 4 * DEPTH + 50;

   logic      clk;
   logic      rst;
   logic      flush;
   logic      disp_valid;
   disp_req_t disp;
   logic      wb_valid;
   wb_req_t   wb;
   logic      commit_accept;
   rob_id_t   disp_id;
   operand_t  rs1;
   operand_t  rs2;
   logic      commit_valid;
   commit_t   commit;
   logic      credit_ret;

   // Reference model, oldest entry at the front of ord_q
   rob_id_t               ord_q[$];
   disp_req_t             m_disp [DEPTH];
   logic [`ROB_DW-1:0]    m_data [DEPTH];
   logic [`ROB_TAG_W-1:0] m_tag  [DEPTH];
   logic                  m_done [DEPTH];
   rob_id_t               m_tail;
   logic                  exp_credit;
   logic                  prev_hold;
   commit_t               prev_commit;
   int                    credits;
   int                    errors;
   int                    cycles;

   rob_top u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   // Youngest dispatched writer of src, with this cycle's writeback seen
   function automatic operand_t model_lookup(input logic [`ROB_REG_AW-1:0] src);
      operand_t res;
      rob_id_t  id;
      res        = '0;
      res.in_arf = 1'b1;
      for (int i = ord_q.size() - 1; i >= 0; i--)
      begin
         id = ord_q[i];
         if (res.in_arf && m_disp[id].rd_we && (m_disp[id].rd_addr == src))
         begin
            res.in_arf  = 1'b0;
            res.prod_id = id;
            if (wb_valid && (wb.id == id))
            begin
               res.in_rob = 1'b1;
               res.data   = wb.data;
            end
            else if (m_done[id])
            begin
               res.in_rob = 1'b1;
               res.data   = m_data[id];
            end
         end
      end
      return res;
   endfunction

   task automatic check_operand(input string name, input operand_t got, input operand_t exp);
      check_eq({name, ".in_arf"}, 64'(got.in_arf), 64'(exp.in_arf));
      check_eq({name, ".in_rob"}, 64'(got.in_rob), 64'(exp.in_rob));
      if (exp.in_rob)
         check_eq({name, ".data"}, 64'(got.data), 64'(exp.data));
      else if (!exp.in_arf)
         check_eq({name, ".prod_id"}, 64'(got.prod_id), 64'(exp.prod_id));
   endtask

   // One clock: drive on the falling edge, check, then advance the model
   task automatic run_cycle(input int n, input bit drain);
      rob_id_t pend[$];
      logic    exp_cv;
      logic    pop;
      @(negedge clk);
      check_eq("credit_ret", 64'(credit_ret), 64'(exp_credit));
      if (credit_ret)
         credits++;
      foreach (ord_q[i])
         if (!m_done[ord_q[i]])
            pend.push_back(ord_q[i]);
      flush         = (n == FLUSH_AT);
      disp_valid    = !flush && !drain && (credits > 0) &&
                      ((n < 30) || ($urandom_range(0, 9) < 6));
      disp.pc       = `ROB_PC_W'($urandom);
      disp.pred_tgt = `ROB_PC_W'($urandom);
      disp.rd_we    = ($urandom_range(0, 9) < 8);
      disp.rd_addr  = `ROB_REG_AW'($urandom_range(0, 3));
      disp.rs1_addr = `ROB_REG_AW'($urandom_range(0, 3));
      disp.rs2_addr = `ROB_REG_AW'($urandom_range(0, 3));
      wb_valid      = !flush && (pend.size() > 0) && (drain || ($urandom_range(0, 9) < 6));
      wb.data       = $urandom;
      wb.tag        = `ROB_TAG_W'($urandom);
      if (pend.size() > 0)
         wb.id = pend[$urandom_range(0, pend.size() - 1)];
      commit_accept = drain || ((n >= 12) && ($urandom_range(0, 9) < 7));
      #1;
      exp_cv = (ord_q.size() > 0) && m_done[ord_q[0]];
      check_eq("commit_valid", 64'(commit_valid), 64'(exp_cv));
      check_eq("disp_id", 64'(disp_id), 64'(m_tail));
      if (exp_cv)
      begin
         check_eq("commit.id", 64'(commit.id), 64'(ord_q[0]));
         check_eq("commit.pc", 64'(commit.pc), 64'(m_disp[ord_q[0]].pc));
         check_eq("commit.pred_tgt", 64'(commit.pred_tgt), 64'(m_disp[ord_q[0]].pred_tgt));
         check_eq("commit.rd_we", 64'(commit.rd_we), 64'(m_disp[ord_q[0]].rd_we));
         check_eq("commit.rd_addr", 64'(commit.rd_addr), 64'(m_disp[ord_q[0]].rd_addr));
         check_eq("commit.data", 64'(commit.data), 64'(m_data[ord_q[0]]));
         check_eq("commit.tag", 64'(commit.tag), 64'(m_tag[ord_q[0]]));
      end
      // Head held by back-pressure
      if (prev_hold)
      begin
         check_eq("commit_valid held", 64'(commit_valid), 64'(1));
         check_eq("commit.data held", 64'(commit.data), 64'(prev_commit.data));
      end
      check_operand("rs1", rs1, model_lookup(disp.rs1_addr));
      check_operand("rs2", rs2, model_lookup(disp.rs2_addr));
      pop         = exp_cv && commit_accept;
      prev_hold   = exp_cv && !commit_accept && !flush;
      prev_commit = commit;
      if (flush)
      begin
         ord_q.delete();
         m_tail     = '0;
         credits    = DEPTH;
         exp_credit = 1'b0;
      end
      else
      begin
         exp_credit = pop;
         if (pop)
            void'(ord_q.pop_front());
         if (wb_valid)
         begin
            m_done[wb.id] = 1'b1;
            m_data[wb.id] = wb.data;
            m_tag[wb.id]  = wb.tag;
         end
         if (disp_valid)
         begin
            ord_q.push_back(m_tail);
            m_disp[m_tail] = disp;
            m_done[m_tail] = 1'b0;
            m_tail++;
            credits--;
         end
      end
   endtask

   initial
   begin
      void'($urandom(32'hfc04));
      rst           = 1'b1;
      flush         = 1'b0;
      disp_valid    = 1'b0;
      disp          = '0;
      wb_valid      = 1'b0;
      wb            = '0;
      commit_accept = 1'b0;
      m_tail        = '0;
      exp_credit    = 1'b0;
      prev_hold     = 1'b0;
      prev_commit   = '0;
      credits       = DEPTH;
      errors        = 0;
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      for (int n = 0; n < N_OPS; n++)
         run_cycle(n, 1'b0);
      // Drain until every dispatched entry has committed
      while (ord_q.size() > 0)
         run_cycle(N_OPS, 1'b1);
      run_cycle(N_OPS, 1'b1);
      $display("Check failures: %0d, assertion failures: %0d",
               errors, u_dut.u_ctrl.u_asserts.fail_cnt);
      if ((errors == 0) && (u_dut.u_ctrl.u_asserts.fail_cnt == 0))
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial
   begin
      cycles = 0;
      while (cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- rob_asserts.sv
/*
 * Concurrent checks on the ROB control
 * Flush width, commit readiness and occupancy bound
 */

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_asserts
(
   input logic                           clk,
   input logic                           rst,
   input logic                           flush,
   input logic                           commit_valid,
   input rob_pkg::rob_id_t               head_id,
   input logic                           wb_en,
   input rob_pkg::rob_id_t               wb_id,
   input logic [`ROB_DEPTH_W:0]          occupancy
);

   localparam logic [`ROB_DEPTH_W:0] MAX_OCC = {1'b1, {`ROB_DEPTH_W{1'b0}}};

   int fail_cnt = 0;

   // Flush is a single-cycle pulse
   flush_pulse: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
   else
   begin
      fail_cnt++;
      $error("flush stayed high for a second cycle");
   end

   // A head that stays put becomes ready only through its own writeback
   commit_done: assert property (@(posedge clk) disable iff (rst)
                                 $rose(commit_valid) && $stable(head_id) |->
                                 $past(wb_en && (wb_id == head_id)))
   else
   begin
      fail_cnt++;
      $error("commit_valid raised on a head slot that got no writeback");
   end

   occ_bound: assert property (@(posedge clk) disable iff (rst) occupancy <= MAX_OCC)
   else
   begin
      fail_cnt++;
      $error("occupancy above the slot count");
   end

endmodule

bind rob_ctrl rob_asserts u_asserts (
   .clk          (clk),
   .rst          (rst),
   .flush        (flush),
   .commit_valid (commit_valid),
   .head_id      (head_id),
   .wb_en        (wb_en),
   .wb_id        (wb_id),
   .occupancy    (occupancy)
);

//--- rob_top.sv
/*
 * Reorder buffer top level
 * Control, entry storage and operand lookup
 */

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_top
(
   input  logic                clk,
   input  logic                rst,
   input  logic                flush,
   input  logic                disp_valid,
   input  rob_pkg::disp_req_t  disp,
   input  logic                wb_valid,
   input  rob_pkg::wb_req_t    wb,
   input  logic                commit_accept,
   output rob_pkg::rob_id_t    disp_id,
   output rob_pkg::operand_t   rs1,
   output rob_pkg::operand_t   rs2,
   output logic                commit_valid,
   output rob_pkg::commit_t    commit,
   output logic                credit_ret
);

   import rob_pkg::*;

   localparam int DEPTH = 1 << `ROB_DEPTH_W;

   logic                          alloc_en;
   rob_id_t                       head_id;
   rob_id_t                       tail_id;
   logic                          wb_en;
   logic [DEPTH-1:0]              slot_valid;
   logic [DEPTH-1:0]              slot_done;
   slot_meta_t [DEPTH-1:0]        slot_meta;
   logic [DEPTH-1:0][`ROB_DW-1:0] slot_data;

   rob_ctrl u_ctrl (
      .clk           (clk),
      .rst           (rst),
      .flush         (flush),
      .disp_valid    (disp_valid),
      .wb_valid      (wb_valid),
      .wb_id         (wb.id),
      .commit_accept (commit_accept),
      .alloc_en      (alloc_en),
      .alloc_id      (disp_id),
      .head_id       (head_id),
      .tail_id       (tail_id),
      .wb_en         (wb_en),
      .slot_valid    (slot_valid),
      .slot_done     (slot_done),
      .commit_valid  (commit_valid),
      .credit_ret    (credit_ret)
   );

   rob_entry_array u_array (
      .clk        (clk),
      .alloc_en   (alloc_en),
      .alloc_id   (disp_id),
      .disp       (disp),
      .wb_en      (wb_en),
      .wb         (wb),
      .head_id    (head_id),
      .slot_meta  (slot_meta),
      .slot_data  (slot_data),
      .head_entry (commit)
   );

   rob_operand_lookup u_lookup (
      .disp       (disp),
      .tail_id    (tail_id),
      .slot_valid (slot_valid),
      .slot_done  (slot_done),
      .slot_meta  (slot_meta),
      .slot_data  (slot_data),
      .wb_valid   (wb_valid),
      .wb         (wb),
      .rs1        (rs1),
      .rs2        (rs2)
   );

endmodule

//--- rob_operand_lookup.sv
/*
 * Operand lookup for a dispatching instruction
 * Finds the youngest older producer of each source in the ROB and
 * reports ARF, ROB data (with writeback bypass) or pending slot
 */

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_operand_lookup
(
   input  rob_pkg::disp_req_t                              disp,
   input  rob_pkg::rob_id_t                                tail_id,
   input  logic [(1 << `ROB_DEPTH_W)-1:0]                  slot_valid,
   input  logic [(1 << `ROB_DEPTH_W)-1:0]                  slot_done,
   input  rob_pkg::slot_meta_t [(1 << `ROB_DEPTH_W)-1:0]   slot_meta,
   input  logic [(1 << `ROB_DEPTH_W)-1:0][`ROB_DW-1:0]     slot_data,
   input  logic                                            wb_valid,
   input  rob_pkg::wb_req_t                                wb,
   output rob_pkg::operand_t                               rs1,
   output rob_pkg::operand_t                               rs2
);

   import rob_pkg::*;

   localparam int DEPTH = 1 << `ROB_DEPTH_W;

   // Walk back from tail-1; the first hit is the youngest writer.
   // At i == DEPTH the index wraps to the tail, i.e. the head of a full ROB
   function automatic operand_t find_src(input logic [`ROB_REG_AW-1:0] src);
      operand_t res;
      logic     found;
      rob_id_t  id;
      res.in_arf  = 1'b1;
      res.in_rob  = 1'b0;
      res.data    = '0;
      res.prod_id = '0;
      found       = 1'b0;
      for (int i = 1; i <= DEPTH; i++)
      begin
         id = tail_id - rob_id_t'(i);
         if (!found && slot_valid[id] && slot_meta[id].rd_we &&
             (slot_meta[id].rd_addr == src))
         begin
            found       = 1'b1;
            res.in_arf  = 1'b0;
            res.prod_id = id;
            // Result arriving this cycle
            if (wb_valid && (wb.id == id))
            begin
               res.in_rob = 1'b1;
               res.data   = wb.data;
            end
            else if (slot_done[id])
            begin
               res.in_rob = 1'b1;
               res.data   = slot_data[id];
            end
         end
      end
      return res;
   endfunction

   always_comb
   begin
      rs1 = find_src(disp.rs1_addr);
      rs2 = find_src(disp.rs2_addr);
   end

endmodule

//--- rob_entry_array.sv
/*
 * Reorder buffer storage
 * Dispatch fields written at allocation, result and tag at writeback;
 * head entry and per-slot destination and data read out
 */

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_entry_array
(
   input  logic                                                clk,
   input  logic                                                alloc_en,
   input  rob_pkg::rob_id_t                                    alloc_id,
   input  rob_pkg::disp_req_t                                  disp,
   input  logic                                                wb_en,
   input  rob_pkg::wb_req_t                                    wb,
   input  rob_pkg::rob_id_t                                    head_id,
   output rob_pkg::slot_meta_t [(1 << `ROB_DEPTH_W)-1:0]       slot_meta,
   output logic [(1 << `ROB_DEPTH_W)-1:0][`ROB_DW-1:0]         slot_data,
   output rob_pkg::commit_t                                    head_entry
);

   import rob_pkg::*;

   localparam int DEPTH = 1 << `ROB_DEPTH_W;

   logic [`ROB_PC_W-1:0]  pc_q   [DEPTH];
   logic [`ROB_PC_W-1:0]  tgt_q  [DEPTH];
   slot_meta_t            meta_q [DEPTH];
   logic [`ROB_DW-1:0]    data_q [DEPTH];
   logic [`ROB_TAG_W-1:0] tag_q  [DEPTH];

   // Fields from dispatch
   always_ff @(posedge clk)
   begin
      if (alloc_en)
      begin
         pc_q[alloc_id]           <= disp.pc;
         tgt_q[alloc_id]          <= disp.pred_tgt;
         meta_q[alloc_id].rd_we   <= disp.rd_we;
         meta_q[alloc_id].rd_addr <= disp.rd_addr;
      end
   end

   // Fields from writeback
   always_ff @(posedge clk)
   begin
      if (wb_en)
      begin
         data_q[wb.id] <= wb.data;
         tag_q[wb.id]  <= wb.tag;
      end
   end

   // Every slot visible to the operand lookup
   always_comb
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         slot_meta[i] = meta_q[i];
         slot_data[i] = data_q[i];
      end
   end

   // Head read port for commit
   always_comb
   begin
      head_entry.id       = head_id;
      head_entry.pc       = pc_q[head_id];
      head_entry.pred_tgt = tgt_q[head_id];
      head_entry.rd_we    = meta_q[head_id].rd_we;
      head_entry.rd_addr  = meta_q[head_id].rd_addr;
      head_entry.data     = data_q[head_id];
      head_entry.tag      = tag_q[head_id];
   end

endmodule

//--- rob_ctrl.sv
/*
 * Reorder buffer control
 * Head and tail pointers, per-slot valid and done bits,
 * commit handshake, flush and dispatch credit return
 */

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_ctrl
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            flush,
   input  logic                            disp_valid,
   input  logic                            wb_valid,
   input  rob_pkg::rob_id_t                wb_id,
   input  logic                            commit_accept,
   output logic                            alloc_en,
   output rob_pkg::rob_id_t                alloc_id,
   output rob_pkg::rob_id_t                head_id,
   output rob_pkg::rob_id_t                tail_id,
   output logic                            wb_en,
   output logic [(1 << `ROB_DEPTH_W)-1:0]  slot_valid,
   output logic [(1 << `ROB_DEPTH_W)-1:0]  slot_done,
   output logic                            commit_valid,
   output logic                            credit_ret
);

   localparam int ID_W = `ROB_DEPTH_W;

   // Extra MSB tells full from empty
   logic [ID_W:0] head_ptr;
   logic [ID_W:0] tail_ptr;
   logic [ID_W:0] occupancy;
   logic          empty;
   logic          pop;

   assign occupancy = tail_ptr - head_ptr;
   assign empty     = (occupancy == '0);

   assign head_id  = head_ptr[ID_W-1:0];
   assign tail_id  = tail_ptr[ID_W-1:0];
   assign alloc_id = tail_id;

   // Dispatcher holds credits, so a dispatch never meets a full ROB
   assign alloc_en = disp_valid;

   // Drop stray writebacks to empty slots
   assign wb_en = wb_valid & slot_valid[wb_id];

   assign commit_valid = ~empty & slot_valid[head_id] & slot_done[head_id];
   assign pop          = commit_valid & commit_accept;

   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         head_ptr <= '0;
         tail_ptr <= '0;
      end
      else
      begin
         if (alloc_en)
            tail_ptr <= tail_ptr + 1'b1;
         if (pop)
            head_ptr <= head_ptr + 1'b1;
      end
   end

   // Allocation last, it owns a freshly reused slot
   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         slot_valid <= '0;
         slot_done  <= '0;
      end
      else
      begin
         if (pop)
         begin
            slot_valid[head_id] <= 1'b0;
            slot_done[head_id]  <= 1'b0;
         end
         if (wb_en)
            slot_done[wb_id] <= 1'b1;
         if (alloc_en)
         begin
            slot_valid[tail_id] <= 1'b1;
            slot_done[tail_id]  <= 1'b0;
         end
      end
   end

   // One credit back per committed entry, lost on flush
   always_ff @(posedge clk)
   begin
      if (rst)
         credit_ret <= 1'b0;
      else
         credit_ret <= pop & ~flush;
   end

endmodule

//--- rob_pkg.sv
/*
 * Reorder buffer types
 * Payloads of the dispatch, writeback, commit and operand lookup paths
 */

`include "rob_defines.svh"

package rob_pkg;

   typedef logic [`ROB_DEPTH_W-1:0] rob_id_t;

   // Dispatched instruction
   typedef struct packed {
      logic [`ROB_PC_W-1:0]   pc;
      logic [`ROB_PC_W-1:0]   pred_tgt;
      logic                   rd_we;
      logic [`ROB_REG_AW-1:0] rd_addr;
      logic [`ROB_REG_AW-1:0] rs1_addr;
      logic [`ROB_REG_AW-1:0] rs2_addr;
   } disp_req_t;

   // Result from a functional unit
   typedef struct packed {
      rob_id_t                id;
      logic [`ROB_DW-1:0]     data;
      logic [`ROB_TAG_W-1:0]  tag;
   } wb_req_t;

   // Oldest entry on its way out
   typedef struct packed {
      rob_id_t                id;
      logic [`ROB_PC_W-1:0]   pc;
      logic [`ROB_PC_W-1:0]   pred_tgt;
      logic                   rd_we;
      logic [`ROB_REG_AW-1:0] rd_addr;
      logic [`ROB_DW-1:0]     data;
      logic [`ROB_TAG_W-1:0]  tag;
   } commit_t;

   // prod_id only means something while the operand is pending
   typedef struct packed {
      logic                   in_arf;
      logic                   in_rob;
      logic [`ROB_DW-1:0]     data;
      rob_id_t                prod_id;
   } operand_t;

   typedef struct packed {
      logic                   rd_we;
      logic [`ROB_REG_AW-1:0] rd_addr;
   } slot_meta_t;

endpackage

//--- rob_defines.svh
/*
 * Reorder buffer configuration
 * Slot count, datapath widths and exception tag width
 */

`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// log2 of the slot count
`define ROB_DEPTH_W 3

// Result data width
`define ROB_DW 32

// Architectural register address width
`define ROB_REG_AW 5

// Word-address PC width
`define ROB_PC_W 30

// Exception tag width
`define ROB_TAG_W 4

`endif
